// ==== logic/us_reg_pkg.sv ====
package us_reg_pkg;

	typedef logic [11:0] apb_addr_t;  // byte address
	typedef logic [31:0] apb_data_t;
	typedef logic [10:0] mux_cnt_t;   // mux board select lines

	// =========================================================================
	// register map
	// =========================================================================
	localparam apb_addr_t REG_CTRL     = 12'h000;  // starts + control levels
	localparam apb_addr_t REG_STATUS   = 12'h004;  // read only, read clears done bits
	localparam apb_addr_t REG_NUM_BITS = 12'h008;  // bits per beamformer transfer
	localparam apb_addr_t REG_TX0      = 12'h00C;  // tx word 31..0
	localparam apb_addr_t REG_TX1      = 12'h010;  // tx word 63..32
	localparam apb_addr_t REG_TX2      = 12'h014;  // tx word 69..64
	localparam apb_addr_t REG_RX0      = 12'h018;  // rx word, read only
	localparam apb_addr_t REG_RX1      = 12'h01C;
	localparam apb_addr_t REG_RX2      = 12'h020;
	localparam apb_addr_t REG_TX_LEN   = 12'h024;  // tx_en pulse length
	localparam apb_addr_t REG_INIT_DLY = 12'h028;  // tx_en rise to fifo_en rise
	localparam apb_addr_t REG_SAMPLES  = 12'h02C;  // fifo_en length
	localparam apb_addr_t REG_MUX      = 12'h030;  // mux_cnt pins

	// CTRL bit positions
	localparam int CTRL_SPI_START   = 0;  // write one, pulse
	localparam int CTRL_ACQ_START   = 1;  // write one, pulse
	localparam int CTRL_PULSER_EN   = 2;
	localparam int CTRL_TXRX_SPI_EN = 3;
	localparam int CTRL_TXRX_SW_OFF = 4;
	localparam int CTRL_BF_RESET    = 5;

endpackage

// ==== logic/us_acq_pkg.sv ====
package us_acq_pkg;

	// =========================================================================
	// beamformer SPI word
	// =========================================================================
	localparam int BF_WORD_W = 70;              // longest LM96570 transfer

	typedef logic [BF_WORD_W-1:0] bf_word_t;
	typedef logic [7:0]           bit_count_t;  // holds up to BF_WORD_W
	typedef logic [31:0]          delay_t;      // clk cycle counts

	// =========================================================================
	// state machines
	// =========================================================================
	typedef enum logic [1:0] {
		SPI_IDLE,
		SPI_WAIT,   // start delay, cs_n still high
		SPI_SHIFT,  // cs_n low, sck running
		SPI_DONE    // cs_n back high
	} spi_state_e;

	typedef enum logic [1:0] {
		ACQ_IDLE,
		ACQ_WAIT,   // start delay
		ACQ_RUN     // tx and sample windows
	} acq_state_e;

	// windows are timed against one run counter from the first tx_en cycle,
	// so the counter needs a bit more than delay_t to reach init_dly + samples

endpackage

// ==== logic/us_reg_decode.sv ====
`timescale 1ns/1ps

module us_reg_decode
	import us_reg_pkg::*, us_acq_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       psel,
	input  logic       penable,
	input  logic       pwrite,
	input  apb_addr_t  paddr,
	input  apb_data_t  pwdata,
	output logic       spi_start,
	output logic       acq_start,
	output bf_word_t   tx_word,
	output bit_count_t num_bits,
	output delay_t     tx_len,
	output delay_t     init_dly,
	output delay_t     samples,
	output logic       pulser_en,
	output logic       txrx_spi_en,
	output logic       txrx_sw_off,
	output logic       bf_reset,
	output mux_cnt_t   mux_cnt
);

	logic wr_acc;    // write access phase
	logic wr_ctrl;   // write access to CTRL

	assign wr_acc  = psel & penable & pwrite;
	assign wr_ctrl = wr_acc && (paddr == REG_CTRL);

	// =========================================================================
	// start pulses
	// =========================================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			spi_start <= 1'b0;
			acq_start <= 1'b0;
		end else begin
			spi_start <= wr_ctrl & pwdata[CTRL_SPI_START];  // high one cycle only
			acq_start <= wr_ctrl & pwdata[CTRL_ACQ_START];
		end
	end

	// =========================================================================
	// configuration registers
	// =========================================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_word     <= '0;
			num_bits    <= '0;
			tx_len      <= '0;
			init_dly    <= '0;
			samples     <= '0;
			pulser_en   <= 1'b0;
			txrx_spi_en <= 1'b0;
			txrx_sw_off <= 1'b0;
			bf_reset    <= 1'b0;
			mux_cnt     <= '0;
		end else if (wr_acc) begin
			case (paddr)
				REG_CTRL: begin                             // level bits only
					pulser_en   <= pwdata[CTRL_PULSER_EN];
					txrx_spi_en <= pwdata[CTRL_TXRX_SPI_EN];
					txrx_sw_off <= pwdata[CTRL_TXRX_SW_OFF];
					bf_reset    <= pwdata[CTRL_BF_RESET];
				end
				REG_NUM_BITS: num_bits <= bit_count_t'(pwdata);  // clamped in spi master
				REG_TX0:      tx_word[31:0] <= pwdata;
				REG_TX1:      tx_word[63:32] <= pwdata;
				REG_TX2:      tx_word[BF_WORD_W-1:64] <= pwdata[BF_WORD_W-65:0];
				REG_TX_LEN:   tx_len <= pwdata;
				REG_INIT_DLY: init_dly <= pwdata;
				REG_SAMPLES:  samples <= pwdata;
				REG_MUX:      mux_cnt <= mux_cnt_t'(pwdata);  // low 11 bits
				default:      ;                              // status, rx, unmapped
			endcase
		end
	end

endmodule

// ==== logic/bf_spi_master.sv ====
`timescale 1ns/1ps

module bf_spi_master
	import us_acq_pkg::*;
#(
	parameter int START_DELAY = 10,  // clk cycles cs_n stays high after start
	parameter int SCK_HALF    = 2    // clk cycles per sck half period
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       spi_start,
	input  bf_word_t   tx_word,
	input  bit_count_t num_bits,
	input  logic       sdi,
	output logic       cs_n,
	output logic       sck,
	output logic       sdo,
	output bf_word_t   rx_word,
	output logic       spi_busy,
	output logic       spi_done
);

	localparam int DLY_W  = $clog2(START_DELAY + 1);
	localparam int HALF_W = $clog2(SCK_HALF + 1);

	spi_state_e        state;
	logic [DLY_W-1:0]  dly_cnt;    // start delay
	logic [HALF_W-1:0] half_cnt;   // sck half period
	bit_count_t        bit_cnt;    // rising edges so far
	bit_count_t        bit_total;  // clamped length, latched at start
	bit_count_t        len_eff;
	bf_word_t          shreg;      // msb is the bit on sdo

	// 0 or anything past the word width means a full word
	assign len_eff  = (num_bits == '0 || num_bits > bit_count_t'(BF_WORD_W)) ?
	                  bit_count_t'(BF_WORD_W) : num_bits;
	assign spi_busy = (state != SPI_IDLE);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= SPI_IDLE;
			dly_cnt   <= '0;
			half_cnt  <= '0;
			bit_cnt   <= '0;
			bit_total <= '0;
			shreg     <= '0;
			rx_word   <= '0;
			cs_n      <= 1'b1;
			sck       <= 1'b0;
			sdo       <= 1'b0;
			spi_done  <= 1'b0;
		end else begin
			spi_done <= 1'b0;
			case (state)
				SPI_IDLE: if (spi_start) begin
					state     <= SPI_WAIT;
					dly_cnt   <= '0;
					bit_cnt   <= '0;
					bit_total <= len_eff;
					shreg     <= tx_word << (BF_WORD_W - int'(len_eff));  // bit n-1 to msb
					rx_word   <= '0;                                      // upper bits stay 0
				end
				SPI_WAIT: if (dly_cnt == DLY_W'(START_DELAY - 1)) begin
					state    <= SPI_SHIFT;
					cs_n     <= 1'b0;
					sdo      <= shreg[BF_WORD_W-1];  // first bit ahead of first rise
					half_cnt <= '0;
				end else begin
					dly_cnt <= dly_cnt + 1'b1;
				end
				SPI_SHIFT: if (half_cnt == HALF_W'(SCK_HALF - 1)) begin
					half_cnt <= '0;
					sck      <= ~sck;
					if (!sck) begin                               // rising, sample
						rx_word <= {rx_word[BF_WORD_W-2:0], sdi};
						bit_cnt <= bit_cnt + 1'b1;
					end else if (bit_cnt == bit_total) begin    // last falling edge
						state    <= SPI_DONE;
						cs_n     <= 1'b1;
						sdo      <= 1'b0;
						spi_done <= 1'b1;
					end else begin                              // falling, next bit out
						sdo   <= shreg[BF_WORD_W-2];
						shreg <= shreg << 1;
					end
				end else begin
					half_cnt <= half_cnt + 1'b1;
				end
				default: state <= SPI_IDLE;  // SPI_DONE
			endcase
		end
	end

endmodule

// ==== logic/acq_sequencer.sv ====
`timescale 1ns/1ps

module acq_sequencer
	import us_acq_pkg::*;
#(
	parameter int START_DELAY = 10  // clk cycles from start to first tx_en
) (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   acq_start,
	input  delay_t tx_len,
	input  delay_t init_dly,
	input  delay_t samples,
	output logic   tx_en,
	output logic   fifo_en,
	output logic   acq_busy,
	output logic   acq_done
);

	localparam int DLY_W = $clog2(START_DELAY + 1);
	localparam int RUN_W = $bits(delay_t) + 1;  // room for init_dly + samples

	acq_state_e       state;
	logic [DLY_W-1:0] dly_cnt;
	logic [RUN_W-1:0] run_cnt;  // cycles since first tx_en cycle
	logic [RUN_W-1:0] tx_end;   // window bounds, latched at start
	logic [RUN_W-1:0] win_beg;
	logic [RUN_W-1:0] win_end;  // 0 when no samples
	logic             run_st;

	assign run_st   = (state == ACQ_RUN);
	assign tx_en    = run_st && (run_cnt < tx_end);
	assign fifo_en  = run_st && (run_cnt >= win_beg) && (run_cnt < win_end);
	assign acq_busy = (state != ACQ_IDLE);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= ACQ_IDLE;
			dly_cnt  <= '0;
			run_cnt  <= '0;
			tx_end   <= '0;
			win_beg  <= '0;
			win_end  <= '0;
			acq_done <= 1'b0;
		end else begin
			acq_done <= 1'b0;
			case (state)
				ACQ_IDLE: if (acq_start) begin
					state   <= ACQ_WAIT;
					dly_cnt <= '0;
					tx_end  <= RUN_W'(tx_len);
					win_beg <= RUN_W'(init_dly);
					win_end <= (samples == '0) ? '0 : RUN_W'(init_dly) + RUN_W'(samples);
				end
				ACQ_WAIT: if (dly_cnt == DLY_W'(START_DELAY - 1)) begin
					state   <= ACQ_RUN;
					run_cnt <= '0;  // first tx_en cycle next
				end else begin
					dly_cnt <= dly_cnt + 1'b1;
				end
				ACQ_RUN: if (run_cnt >= tx_end && run_cnt >= win_end) begin  // both closed
					state    <= ACQ_IDLE;
					acq_done <= 1'b1;
				end else begin
					run_cnt <= run_cnt + 1'b1;
				end
				default: state <= ACQ_IDLE;
			endcase
		end
	end

endmodule

// ==== logic/us_status_result.sv ====
`timescale 1ns/1ps

module us_status_result
	import us_reg_pkg::*, us_acq_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       psel,
	input  logic       penable,
	input  logic       pwrite,
	input  apb_addr_t  paddr,
	input  bf_word_t   rx_word,
	input  logic       spi_busy,
	input  logic       spi_done,
	input  logic       acq_busy,
	input  logic       acq_done,
	input  bit_count_t num_bits,
	input  bf_word_t   tx_word,
	input  delay_t     tx_len,
	input  delay_t     init_dly,
	input  delay_t     samples,
	input  logic       pulser_en,
	input  logic       txrx_spi_en,
	input  logic       txrx_sw_off,
	input  logic       bf_reset,
	input  mux_cnt_t   mux_cnt,
	output apb_data_t  prdata,
	output logic       pslverr
);

	logic      rd_acc;     // read access phase
	logic      status_rd;
	logic      spi_flag;   // sticky done bits
	logic      acq_flag;
	logic      addr_hit;
	apb_data_t rdata;

	assign rd_acc    = psel & penable & ~pwrite;
	assign status_rd = rd_acc && (paddr == REG_STATUS);

	// done pulse beats the clearing read
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			spi_flag <= 1'b0;
			acq_flag <= 1'b0;
		end else begin
			spi_flag <= spi_done | (spi_flag & ~status_rd);
			acq_flag <= acq_done | (acq_flag & ~status_rd);
		end
	end

	// =========================================================================
	// read mux
	// =========================================================================
	always_comb begin
		rdata    = '0;
		addr_hit = 1'b1;
		case (paddr)
			REG_CTRL: begin                           // start bits read 0
				rdata[CTRL_PULSER_EN]   = pulser_en;
				rdata[CTRL_TXRX_SPI_EN] = txrx_spi_en;
				rdata[CTRL_TXRX_SW_OFF] = txrx_sw_off;
				rdata[CTRL_BF_RESET]    = bf_reset;
			end
			REG_STATUS:   rdata[3:0] = {acq_busy, spi_busy, acq_flag, spi_flag};
			REG_NUM_BITS: rdata = apb_data_t'(num_bits);
			REG_TX0:      rdata = tx_word[31:0];
			REG_TX1:      rdata = tx_word[63:32];
			REG_TX2:      rdata = apb_data_t'(tx_word[BF_WORD_W-1:64]);
			REG_RX0:      rdata = rx_word[31:0];
			REG_RX1:      rdata = rx_word[63:32];
			REG_RX2:      rdata = apb_data_t'(rx_word[BF_WORD_W-1:64]);
			REG_TX_LEN:   rdata = tx_len;
			REG_INIT_DLY: rdata = init_dly;
			REG_SAMPLES:  rdata = samples;
			REG_MUX:      rdata = apb_data_t'(mux_cnt);
			default:      addr_hit = 1'b0;           // unmapped
		endcase
	end

	assign prdata  = rd_acc ? rdata : '0;  // only in read access phase
	assign pslverr = rd_acc & ~addr_hit;

endmodule

// ==== logic/us_ctrl_top.sv ====
`timescale 1ns/1ps

module us_ctrl_top
	import us_reg_pkg::*, us_acq_pkg::*;
#(
	parameter int START_DELAY = 10,  // start pulse to spi / tx_en action
	parameter int SCK_HALF    = 2    // sck = clk / (2 * SCK_HALF)
) (
	input  logic      clk,
	input  logic      rst_n,
	// apb slave
	input  logic      psel,
	input  logic      penable,
	input  logic      pwrite,
	input  apb_addr_t paddr,
	input  apb_data_t pwdata,
	output apb_data_t prdata,
	output logic      pready,
	output logic      pslverr,
	// beamformer spi
	output logic      bf_spi_cs_n,
	output logic      bf_spi_sck,
	output logic      bf_spi_sdo,
	input  logic      bf_spi_sdi,
	// acquisition
	output logic      bf_tx_en,
	output logic      fifo_en,
	// board control
	output logic      pulser_en,
	output logic      txrx_spi_en,
	output logic      txrx_sw_off,
	output logic      bf_reset,
	output mux_cnt_t  mux_cnt
);

	logic       spi_start;  // decode to execute
	logic       acq_start;
	bf_word_t   tx_word;
	bit_count_t num_bits;
	delay_t     tx_len;
	delay_t     init_dly;
	delay_t     samples;
	bf_word_t   rx_word;    // execute to result
	logic       spi_busy;
	logic       spi_done;
	logic       acq_busy;
	logic       acq_done;

	assign pready = 1'b1;  // no wait states

	us_reg_decode decode_i (.*);

	bf_spi_master #(
		.START_DELAY (START_DELAY),
		.SCK_HALF    (SCK_HALF)
	) spi_i (
		.cs_n (bf_spi_cs_n),
		.sck  (bf_spi_sck),
		.sdo  (bf_spi_sdo),
		.sdi  (bf_spi_sdi),
		.*
	);

	acq_sequencer #(
		.START_DELAY (START_DELAY)
	) acq_i (
		.tx_en (bf_tx_en),
		.*
	);

	us_status_result result_i (.*);

endmodule

// ==== verif/us_ctrl_tb.sv ====
`timescale 1ns/1ps

module us_ctrl_tb
	import us_reg_pkg::*;
();

	localparam int START_DELAY    = 10;     // dut defaults
	localparam int SCK_HALF       = 2;
	localparam int WORD_W         = 70;     // beamformer word
	localparam int TIMEOUT_CYCLES = 20000;  // whole run is well under 2000 cycles

	logic      clk;
	logic      rst_n;
	logic      psel;
	logic      penable;
	logic      pwrite;
	apb_addr_t paddr;
	apb_data_t pwdata;
	apb_data_t prdata;
	logic      pready;
	logic      pslverr;
	logic      cs_n;
	logic      sck;
	logic      sdo;
	logic      tx_en;
	logic      fifo_en;
	logic      pulser_en;
	logic      txrx_spi_en;
	logic      txrx_sw_off;
	logic      bf_reset;
	mux_cnt_t  mux_cnt;

	integer seed;
	int     errors;
	int     checks;
	int     cycle_cnt;
	int     sck_rises;    // sck edges since last clear
	int     tx_high;      // tx_en high cycles
	int     fifo_high;
	int     tx_first;     // cycle of first tx_en
	int     fifo_first;

	us_ctrl_top #(
		.START_DELAY (START_DELAY),
		.SCK_HALF    (SCK_HALF)
	) dut_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.bf_spi_cs_n (cs_n),
		.bf_spi_sck  (sck),
		.bf_spi_sdo  (sdo),
		.bf_spi_sdi  (sdo),  // loopback
		.bf_tx_en    (tx_en),
		.fifo_en     (fifo_en),
		.pulser_en   (pulser_en),
		.txrx_spi_en (txrx_spi_en),
		.txrx_sw_off (txrx_sw_off),
		.bf_reset    (bf_reset),
		.mux_cnt     (mux_cnt)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;  // 100 MHz

	// =========================================================================
	// monitors
	// =========================================================================
	always @(posedge sck) sck_rises++;

	always @(negedge clk) begin  // outputs settled mid cycle
		cycle_cnt++;
		if (tx_en) begin
			if (tx_high == 0) tx_first = cycle_cnt;
			tx_high++;
		end
		if (fifo_en) begin
			if (fifo_high == 0) fifo_first = cycle_cnt;
			fifo_high++;
		end
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation failed");
			$finish;
		end
	end

	// =========================================================================
	// apb and check tasks
	// =========================================================================
	task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
		@(posedge clk);
		psel    <= 1'b1;  // setup phase
		pwrite  <= 1'b1;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge clk);
		penable <= 1'b1;  // access phase
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
		@(posedge clk);
		psel    <= 1'b1;
		pwrite  <= 1'b0;
		paddr   <= addr;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);   // prdata valid in access phase
		data = prdata;
		err  = pslverr;
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic check(input string name, input logic [WORD_W-1:0] exp,
		input logic [WORD_W-1:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("FAILED %s: expected %0h, actual %0h", name, exp, act);
		end
	endtask

	task automatic write_readback(input apb_addr_t addr, input apb_data_t data,
		input apb_data_t mask, input string name);
		apb_data_t rd;
		logic      err;
		apb_write(addr, data);
		apb_read(addr, rd, err);
		check(name, data & mask, rd);
		check({name, " pslverr"}, 1'b0, err);
	endtask

	// poll status until the sticky bit shows, then see it cleared
	task automatic wait_done(input int idx, input string name);
		apb_data_t st;
		logic      err;
		st = '0;
		while (st[idx] !== 1'b1) begin
			apb_read(REG_STATUS, st, err);
		end
		apb_read(REG_STATUS, st, err);
		check({name, " done clears"}, 1'b0, st[idx]);
	endtask

	// =========================================================================
	// tests
	// =========================================================================
	task automatic reset_values();
		apb_data_t rd;
		apb_addr_t addr;
		logic      err;
		check("reset cs_n", 1'b1, cs_n);
		check("reset pready", 1'b1, pready);
		check("reset pins", '0, {tx_en, fifo_en, pulser_en, txrx_spi_en, txrx_sw_off,
			bf_reset, mux_cnt});
		for (addr = REG_CTRL; addr <= REG_MUX; addr += 12'h4) begin  // map is contiguous
			apb_read(addr, rd, err);
			check($sformatf("reset reg %0h", addr), '0, rd);
		end
	endtask

	task automatic reg_access();
		apb_data_t ctrl_val;
		apb_data_t mux_val;
		apb_data_t rd;
		logic      err;
		ctrl_val = $random(seed) & 32'h3C;  // level bits only, no starts
		mux_val  = $random(seed);
		write_readback(REG_TX0, $random(seed), 32'hFFFF_FFFF, "rw tx0");
		write_readback(REG_TX1, $random(seed), 32'hFFFF_FFFF, "rw tx1");
		write_readback(REG_TX2, $random(seed), 32'h3F, "rw tx2");
		write_readback(REG_NUM_BITS, $random(seed), 32'hFF, "rw num_bits");
		write_readback(REG_TX_LEN, $random(seed), 32'hFFFF_FFFF, "rw tx_len");
		write_readback(REG_INIT_DLY, $random(seed), 32'hFFFF_FFFF, "rw init_dly");
		write_readback(REG_SAMPLES, $random(seed), 32'hFFFF_FFFF, "rw samples");
		write_readback(REG_MUX, mux_val, 32'h7FF, "rw mux");
		write_readback(REG_CTRL, ctrl_val, 32'h3C, "rw ctrl");
		check("pin pulser_en", ctrl_val[2], pulser_en);
		check("pin txrx_spi_en", ctrl_val[3], txrx_spi_en);
		check("pin txrx_sw_off", ctrl_val[4], txrx_sw_off);
		check("pin bf_reset", ctrl_val[5], bf_reset);
		check("pin mux_cnt", mux_val[10:0], mux_cnt);
		apb_read(12'h040, rd, err);  // unmapped
		check("unmapped pslverr", 1'b1, err);
	endtask

	task automatic spi_loopback(input int nbits);
		logic [WORD_W-1:0] word;
		logic [WORD_W-1:0] mask;
		logic [WORD_W-1:0] rx;
		apb_data_t         rd0;
		apb_data_t         rd1;
		apb_data_t         rd2;
		logic              err;
		string             name;
		name = $sformatf("spi %0d bits", nbits);
		word = WORD_W'({$random(seed), $random(seed), $random(seed)});
		mask = {WORD_W{1'b1}} >> (WORD_W - nbits);  // low nbits
		apb_write(REG_NUM_BITS, nbits);
		apb_write(REG_TX0, word[31:0]);
		apb_write(REG_TX1, word[63:32]);
		apb_write(REG_TX2, 32'(word[69:64]));
		sck_rises = 0;
		apb_write(REG_CTRL, 32'h1);
		wait_done(0, name);
		apb_read(REG_RX0, rd0, err);
		apb_read(REG_RX1, rd1, err);
		apb_read(REG_RX2, rd2, err);
		rx = {rd2[5:0], rd1, rd0};
		check({name, " rx word"}, word & mask, rx);
		check({name, " sck edges"}, nbits, sck_rises);
		check({name, " cs_n idle"}, 1'b1, cs_n);
	endtask

	task automatic acq_windows();
		int len;
		int dly;
		int nsamp;
		len   = 1 + ($random(seed) & 15);
		dly   = $random(seed) & 15;
		nsamp = 1 + ($random(seed) & 15);
		apb_write(REG_TX_LEN, len);
		apb_write(REG_INIT_DLY, dly);
		apb_write(REG_SAMPLES, nsamp);
		tx_high   = 0;
		fifo_high = 0;
		apb_write(REG_CTRL, 32'h2);
		wait_done(1, "acq");  // poll until acq done is sticky
		check("acq tx_en cycles", len, tx_high);
		check("acq fifo_en cycles", nsamp, fifo_high);
		check("acq fifo_en offset", dly, fifo_first - tx_first);
	endtask

	task automatic busy_restart();
		apb_data_t st;
		logic      err;
		apb_write(REG_TX_LEN, 20);
		apb_write(REG_INIT_DLY, 4);
		apb_write(REG_SAMPLES, 8);
		tx_high   = 0;
		fifo_high = 0;
		apb_write(REG_CTRL, 32'h2);
		apb_read(REG_STATUS, st, err);
		check("acq busy", 1'b1, st[3]);
		while (tx_en !== 1'b1) @(negedge clk);  // into the tx window
		apb_write(REG_CTRL, 32'h2);  // lands mid run
		wait_done(1, "acq restart");
		check("acq restart tx_en cycles", 20, tx_high);
		apb_write(REG_NUM_BITS, 24);
		sck_rises = 0;
		apb_write(REG_CTRL, 32'h1);
		apb_read(REG_STATUS, st, err);
		check("spi busy", 1'b1, st[2]);
		while (cs_n !== 1'b0) @(negedge clk);  // past the start delay
		apb_write(REG_CTRL, 32'h1);  // still shifting
		wait_done(0, "spi restart");
		check("spi restart sck edges", 24, sck_rises);
	endtask

	// =========================================================================
	// main sequence
	// =========================================================================
	initial begin
		seed       = 32'h3e691463;
		errors     = 0;
		checks     = 0;
		cycle_cnt  = 0;
		sck_rises  = 0;
		tx_high    = 0;
		fifo_high  = 0;
		tx_first   = 0;
		fifo_first = 0;
		rst_n      = 1'b0;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = '0;
		pwdata     = '0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		reset_values();
		reg_access();
		spi_loopback(WORD_W);
		spi_loopback(16);
		acq_windows();
		busy_restart();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== src.f ====
logic/us_reg_pkg.sv
logic/us_acq_pkg.sv
logic/us_reg_decode.sv
logic/bf_spi_master.sv
logic/acq_sequencer.sv
logic/us_status_result.sv
logic/us_ctrl_top.sv
verif/us_ctrl_tb.sv
